// ==== hdl/la_decode_config.svh ====
`ifndef LA_DECODE_CONFIG_SVH
`define LA_DECODE_CONFIG_SVH

// data path and immediate width
`define LA_XLEN 32

// register file address
`define LA_REG_AW 5

`define LA_CSR_NUM_W 14

// control code widths
`define LA_ALU_OP_W 5
`define LA_NPC_OP_W 5

`endif

// ==== hdl/la_inst_pkg.sv ====
`include "la_decode_config.svh"

package la_inst_pkg;

  // 3R and system layout, op field runs down to bit 15
  typedef struct packed {
    logic [16:0]           op_31_15;
    logic [`LA_REG_AW-1:0] rk;
    logic [`LA_REG_AW-1:0] rj;
    logic [`LA_REG_AW-1:0] rd;
  } inst_r_t;

  // immediate layout
  // I20, I16 and I26 are stitched together from these fields
  typedef struct packed {
    logic [5:0]            op_31_26;
    logic [3:0]            op_25_22;
    logic [11:0]           imm_21_10;
    logic [`LA_REG_AW-1:0] rj;
    logic [`LA_REG_AW-1:0] rd;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_word_u;

  typedef enum logic [5:0] {
    ID_INE = 6'd0,
    // three-register alu
    ID_ADD_W, ID_SUB_W, ID_SLT, ID_SLTU, ID_NOR, ID_AND,
    ID_OR, ID_XOR, ID_SLL_W, ID_SRL_W, ID_SRA_W,
    // immediate alu
    ID_SLLI_W, ID_SRLI_W, ID_SRAI_W, ID_ADDI_W, ID_SLTI,
    ID_SLTUI, ID_ANDI, ID_ORI, ID_XORI, ID_LU12I_W, ID_PCADDU12I,
    // memory
    ID_LD_B, ID_LD_H, ID_LD_W, ID_LD_BU, ID_LD_HU,
    ID_ST_B, ID_ST_H, ID_ST_W,
    // flow change
    ID_JIRL, ID_B, ID_BL,
    ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU,
    // csr and system
    ID_CSRRD, ID_CSRWR, ID_CSRXCHG, ID_ERTN, ID_SYSCALL, ID_BREAK
  } inst_id_e;

endpackage

// ==== hdl/la_ctrl_pkg.sv ====
`include "la_decode_config.svh"

package la_ctrl_pkg;

  // numbering must stay in step with the execute stage alu
  typedef enum logic [`LA_ALU_OP_W-1:0] {
    ALU_NOP  = 5'd0,  ALU_LUI  = 5'd1,
    ALU_ADD  = 5'd3,  ALU_SUB  = 5'd4,
    ALU_BNE  = 5'd5,  ALU_BLT  = 5'd6,
    ALU_BGE  = 5'd7,  ALU_BLTU = 5'd8,
    ALU_BGEU = 5'd9,  ALU_SLT  = 5'd10,
    ALU_SLTU = 5'd11, ALU_XOR  = 5'd12,
    ALU_OR   = 5'd13, ALU_AND  = 5'd14,
    ALU_SLL  = 5'd15, ALU_SRL  = 5'd16,
    ALU_SRA  = 5'd17, ALU_NOR  = 5'd18,
    ALU_BEQ  = 5'd19, ALU_CSR  = 5'd27
  } alu_op_e;

  typedef enum logic [`LA_NPC_OP_W-1:0] {
    NPC_PLUS4  = 5'd0,
    NPC_BRANCH = 5'd1,   // taken decided in execute
    NPC_B      = 5'd6,   // b and bl
    NPC_ERTN   = 5'd8,
    NPC_JIRL   = 5'd24
  } npc_op_e;

  // register write data source
  typedef enum logic [1:0] {
    WD_ALU = 2'd0,
    WD_MEM = 2'd1,
    WD_PC  = 2'd2
  } wd_sel_e;

  typedef enum logic [2:0] {
    DM_W  = 3'd0,
    DM_H  = 3'd1,
    DM_HU = 3'd2,
    DM_B  = 3'd3,
    DM_BU = 3'd4
  } dm_type_e;

endpackage

// ==== hdl/la_inst_match.sv ====
`timescale 1ns/1ns
`include "la_decode_config.svh"

module la_inst_match (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  la_inst_pkg::inst_word_u i_inst,
  input  logic [`LA_XLEN-1:0]     i_pc,
  input  logic                    i_ready,
  output logic                    o_ready,
  output logic                    o_valid,
  output la_inst_pkg::inst_id_e   o_id,
  output la_inst_pkg::inst_word_u o_inst,
  output logic [`LA_XLEN-1:0]     o_pc
);

  la_inst_pkg::inst_id_e id_nxt;

  ////////////////////////////////////////////////////////////
  // opcode match

  always_comb begin
    id_nxt = la_inst_pkg::ID_INE;  // unmatched words stay INE
    // 3R, shift-immediate and system ops share the long opcode
    case (i_inst.r.op_31_15)
      17'h00020: id_nxt = la_inst_pkg::ID_ADD_W;
      17'h00022: id_nxt = la_inst_pkg::ID_SUB_W;
      17'h00024: id_nxt = la_inst_pkg::ID_SLT;
      17'h00025: id_nxt = la_inst_pkg::ID_SLTU;
      17'h00028: id_nxt = la_inst_pkg::ID_NOR;
      17'h00029: id_nxt = la_inst_pkg::ID_AND;
      17'h0002a: id_nxt = la_inst_pkg::ID_OR;
      17'h0002b: id_nxt = la_inst_pkg::ID_XOR;
      17'h0002e: id_nxt = la_inst_pkg::ID_SLL_W;
      17'h0002f: id_nxt = la_inst_pkg::ID_SRL_W;
      17'h00030: id_nxt = la_inst_pkg::ID_SRA_W;
      17'h00054: id_nxt = la_inst_pkg::ID_BREAK;
      17'h00056: id_nxt = la_inst_pkg::ID_SYSCALL;
      17'h00081: id_nxt = la_inst_pkg::ID_SLLI_W;
      17'h00089: id_nxt = la_inst_pkg::ID_SRLI_W;
      17'h00091: id_nxt = la_inst_pkg::ID_SRAI_W;
      17'h00c90: begin
        if (i_inst.r.rk == 5'h0e) begin
          id_nxt = la_inst_pkg::ID_ERTN;
        end
      end
      default: ;
    endcase

    // short opcode forms, never overlap the ones above
    case (i_inst.i.op_31_26)
      6'h00: begin
        case (i_inst.i.op_25_22)
          4'h8: id_nxt = la_inst_pkg::ID_SLTI;
          4'h9: id_nxt = la_inst_pkg::ID_SLTUI;
          4'ha: id_nxt = la_inst_pkg::ID_ADDI_W;
          4'hd: id_nxt = la_inst_pkg::ID_ANDI;
          4'he: id_nxt = la_inst_pkg::ID_ORI;
          4'hf: id_nxt = la_inst_pkg::ID_XORI;
          default: ;
        endcase
      end
      6'h01: begin
        // inst[31:24] == 8'h04, rj picks the csr op
        if (i_inst.i.op_25_22[3:2] == 2'b00) begin
          if (i_inst.i.rj == 5'd0) begin
            id_nxt = la_inst_pkg::ID_CSRRD;
          end else if (i_inst.i.rj == 5'd1) begin
            id_nxt = la_inst_pkg::ID_CSRWR;
          end else begin
            id_nxt = la_inst_pkg::ID_CSRXCHG;
          end
        end
      end
      6'h05: begin
        if (!i_inst.i.op_25_22[3]) begin
          id_nxt = la_inst_pkg::ID_LU12I_W;
        end
      end
      6'h07: begin
        if (!i_inst.i.op_25_22[3]) begin
          id_nxt = la_inst_pkg::ID_PCADDU12I;
        end
      end
      6'h0a: begin
        case (i_inst.i.op_25_22)
          4'h0: id_nxt = la_inst_pkg::ID_LD_B;
          4'h1: id_nxt = la_inst_pkg::ID_LD_H;
          4'h2: id_nxt = la_inst_pkg::ID_LD_W;
          4'h4: id_nxt = la_inst_pkg::ID_ST_B;
          4'h5: id_nxt = la_inst_pkg::ID_ST_H;
          4'h6: id_nxt = la_inst_pkg::ID_ST_W;
          4'h8: id_nxt = la_inst_pkg::ID_LD_BU;
          4'h9: id_nxt = la_inst_pkg::ID_LD_HU;
          default: ;
        endcase
      end
      6'h13: id_nxt = la_inst_pkg::ID_JIRL;
      6'h14: id_nxt = la_inst_pkg::ID_B;
      6'h15: id_nxt = la_inst_pkg::ID_BL;
      6'h16: id_nxt = la_inst_pkg::ID_BEQ;
      6'h17: id_nxt = la_inst_pkg::ID_BNE;
      6'h18: id_nxt = la_inst_pkg::ID_BLT;
      6'h19: id_nxt = la_inst_pkg::ID_BGE;
      6'h1a: id_nxt = la_inst_pkg::ID_BLTU;
      6'h1b: id_nxt = la_inst_pkg::ID_BGEU;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register slice

  assign o_ready = !o_valid || i_ready;  // empty or draining this cycle

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_id   <= id_nxt;
      o_inst <= i_inst;
      o_pc   <= i_pc;
    end
  end

endmodule

// ==== hdl/la_imm_gen.sv ====
`timescale 1ns/1ns
`include "la_decode_config.svh"

module la_imm_gen (
  input  la_inst_pkg::inst_id_e   i_id,
  input  la_inst_pkg::inst_word_u i_inst,
  output logic [`LA_XLEN-1:0]     o_imm_alu,
  output logic [`LA_XLEN-1:0]     o_imm_pc
);

  logic [19:0]         i20;
  logic [15:0]         i16;
  logic [25:0]         i26;
  logic [11:0]         i12;
  logic [`LA_XLEN-1:0] off16;
  logic [`LA_XLEN-1:0] off26;

  assign i12   = i_inst.i.imm_21_10;
  assign i20   = {i_inst.i.op_25_22[2:0], i12, i_inst.i.rj};  // inst[24:5]
  assign i16   = {i_inst.i.op_25_22, i12};
  assign i26   = {i_inst.i.rj, i_inst.i.rd, i16};  // upper 10 bits live in rj/rd
  assign off16 = {{(`LA_XLEN-18){i16[15]}}, i16, 2'b00};
  assign off26 = {{(`LA_XLEN-28){i26[25]}}, i26, 2'b00};

  always_comb begin
    case (i_id)
      la_inst_pkg::ID_JIRL, la_inst_pkg::ID_BL:
        o_imm_alu = {{(`LA_XLEN-3){1'b0}}, 3'd4};  // link address pc+4
      la_inst_pkg::ID_LU12I_W, la_inst_pkg::ID_PCADDU12I:
        o_imm_alu = {i20, {(`LA_XLEN-20){1'b0}}};
      la_inst_pkg::ID_BEQ, la_inst_pkg::ID_BNE, la_inst_pkg::ID_BLT,
      la_inst_pkg::ID_BGE, la_inst_pkg::ID_BLTU, la_inst_pkg::ID_BGEU:
        o_imm_alu = off16;
      la_inst_pkg::ID_B:
        o_imm_alu = off26;
      la_inst_pkg::ID_SLLI_W, la_inst_pkg::ID_SRLI_W, la_inst_pkg::ID_SRAI_W:
        o_imm_alu = {{(`LA_XLEN-5){1'b0}}, i12[4:0]};
      la_inst_pkg::ID_ANDI, la_inst_pkg::ID_ORI, la_inst_pkg::ID_XORI:
        o_imm_alu = {{(`LA_XLEN-12){1'b0}}, i12};
      default:
        o_imm_alu = {{(`LA_XLEN-12){i12[11]}}, i12};  // si12
    endcase
  end

  // pc-relative target offset
  always_comb begin
    case (i_id)
      la_inst_pkg::ID_B, la_inst_pkg::ID_BL:
        o_imm_pc = off26;
      la_inst_pkg::ID_JIRL, la_inst_pkg::ID_BEQ, la_inst_pkg::ID_BNE,
      la_inst_pkg::ID_BLT, la_inst_pkg::ID_BGE, la_inst_pkg::ID_BLTU,
      la_inst_pkg::ID_BGEU:
        o_imm_pc = off16;
      default:
        o_imm_pc = '0;
    endcase
  end

endmodule

// ==== hdl/la_ctrl_gen.sv ====
`timescale 1ns/1ns
`include "la_decode_config.svh"

module la_ctrl_gen (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_valid,
  input  la_inst_pkg::inst_id_e    i_id,
  input  la_inst_pkg::inst_word_u  i_inst,
  input  logic [`LA_XLEN-1:0]      i_pc,
  input  logic                     i_ready,
  output logic                     o_ready,
  output logic                     o_valid,
  output logic [`LA_XLEN-1:0]      o_pc,
  output logic [`LA_REG_AW-1:0]    o_rd,
  output logic [`LA_REG_AW-1:0]    o_rs1,
  output logic [`LA_REG_AW-1:0]    o_rs2,
  output logic                     o_reg_write,
  output logic                     o_mem_write,
  output logic                     o_mem_read,
  output la_ctrl_pkg::alu_op_e     o_alu_op,
  output la_ctrl_pkg::npc_op_e     o_npc_op,
  output logic                     o_alu_src1_pc,
  output logic                     o_alu_src2_imm,
  output la_ctrl_pkg::wd_sel_e     o_wd_sel,
  output la_ctrl_pkg::dm_type_e    o_dm_type,
  output logic [`LA_XLEN-1:0]      o_imm_alu,
  output logic [`LA_XLEN-1:0]      o_imm_pc,
  output logic [`LA_CSR_NUM_W-1:0] o_csr_num,
  output logic                     o_csr_mask_en,
  output logic                     o_csr_write,
  output logic                     o_ertn,
  output logic                     o_sys,
  output logic                     o_brk,
  output logic                     o_ine
);

  la_ctrl_pkg::alu_op_e  alu_op_nxt;
  la_ctrl_pkg::npc_op_e  npc_op_nxt;
  la_ctrl_pkg::wd_sel_e  wd_sel_nxt;
  la_ctrl_pkg::dm_type_e dm_type_nxt;
  logic                  reg_write_nxt;
  logic                  mem_write_nxt;
  logic                  mem_read_nxt;
  logic                  src1_pc_nxt;
  logic                  src2_imm_nxt;
  logic                  rs2_is_rd;
  logic                  rd_is_r1;
  logic                  csr_write_nxt;
  logic                  csr_mask_nxt;
  logic                  ine_nxt;
  logic [`LA_XLEN-1:0]   imm_alu_nxt;
  logic [`LA_XLEN-1:0]   imm_pc_nxt;

  la_imm_gen u_imm_gen (
    .i_id      (i_id),
    .i_inst    (i_inst),
    .o_imm_alu (imm_alu_nxt),
    .o_imm_pc  (imm_pc_nxt)
  );

  ////////////////////////////////////////////////////////////
  // per-class enables, INE leaves everything off

  always_comb begin
    reg_write_nxt = 1'b0;
    mem_write_nxt = 1'b0;
    mem_read_nxt  = 1'b0;
    src1_pc_nxt   = 1'b0;
    src2_imm_nxt  = 1'b0;
    rs2_is_rd     = 1'b0;
    rd_is_r1      = 1'b0;
    csr_write_nxt = 1'b0;
    csr_mask_nxt  = 1'b0;
    ine_nxt       = 1'b0;
    wd_sel_nxt    = la_ctrl_pkg::WD_ALU;
    npc_op_nxt    = la_ctrl_pkg::NPC_PLUS4;
    case (i_id)
      la_inst_pkg::ID_ADD_W, la_inst_pkg::ID_SUB_W, la_inst_pkg::ID_SLT,
      la_inst_pkg::ID_SLTU, la_inst_pkg::ID_NOR, la_inst_pkg::ID_AND,
      la_inst_pkg::ID_OR, la_inst_pkg::ID_XOR, la_inst_pkg::ID_SLL_W,
      la_inst_pkg::ID_SRL_W, la_inst_pkg::ID_SRA_W, la_inst_pkg::ID_CSRRD:
        reg_write_nxt = 1'b1;
      la_inst_pkg::ID_SLLI_W, la_inst_pkg::ID_SRLI_W, la_inst_pkg::ID_SRAI_W,
      la_inst_pkg::ID_ADDI_W, la_inst_pkg::ID_SLTI, la_inst_pkg::ID_SLTUI,
      la_inst_pkg::ID_ANDI, la_inst_pkg::ID_ORI, la_inst_pkg::ID_XORI,
      la_inst_pkg::ID_LU12I_W: begin
        reg_write_nxt = 1'b1;
        src2_imm_nxt  = 1'b1;
      end
      la_inst_pkg::ID_PCADDU12I: begin
        reg_write_nxt = 1'b1;
        src2_imm_nxt  = 1'b1;
        src1_pc_nxt   = 1'b1;
      end
      la_inst_pkg::ID_LD_B, la_inst_pkg::ID_LD_H, la_inst_pkg::ID_LD_W,
      la_inst_pkg::ID_LD_BU, la_inst_pkg::ID_LD_HU: begin
        reg_write_nxt = 1'b1;
        src2_imm_nxt  = 1'b1;
        mem_read_nxt  = 1'b1;
        wd_sel_nxt    = la_ctrl_pkg::WD_MEM;
      end
      la_inst_pkg::ID_ST_B, la_inst_pkg::ID_ST_H, la_inst_pkg::ID_ST_W: begin
        mem_write_nxt = 1'b1;
        src2_imm_nxt  = 1'b1;
        rs2_is_rd     = 1'b1;  // store data comes from rd
      end
      la_inst_pkg::ID_JIRL, la_inst_pkg::ID_BL: begin
        reg_write_nxt = 1'b1;
        src1_pc_nxt   = 1'b1;
        src2_imm_nxt  = 1'b1;
        wd_sel_nxt    = la_ctrl_pkg::WD_PC;
        rd_is_r1      = (i_id == la_inst_pkg::ID_BL);
        npc_op_nxt    = (i_id == la_inst_pkg::ID_BL) ? la_ctrl_pkg::NPC_B
                                                     : la_ctrl_pkg::NPC_JIRL;
      end
      la_inst_pkg::ID_B:
        npc_op_nxt = la_ctrl_pkg::NPC_B;
      la_inst_pkg::ID_BEQ, la_inst_pkg::ID_BNE, la_inst_pkg::ID_BLT,
      la_inst_pkg::ID_BGE, la_inst_pkg::ID_BLTU, la_inst_pkg::ID_BGEU: begin
        npc_op_nxt = la_ctrl_pkg::NPC_BRANCH;
        rs2_is_rd  = 1'b1;  // compare rj against rd
      end
      la_inst_pkg::ID_CSRWR, la_inst_pkg::ID_CSRXCHG: begin
        reg_write_nxt = 1'b1;
        rs2_is_rd     = 1'b1;
        csr_write_nxt = 1'b1;
        csr_mask_nxt  = (i_id == la_inst_pkg::ID_CSRXCHG);  // mask in rj
      end
      la_inst_pkg::ID_ERTN:
        npc_op_nxt = la_ctrl_pkg::NPC_ERTN;
      la_inst_pkg::ID_SYSCALL, la_inst_pkg::ID_BREAK: ;
      default:
        ine_nxt = 1'b1;
    endcase
  end

  // alu code, source numbering
  always_comb begin
    case (i_id)
      la_inst_pkg::ID_SUB_W:                          alu_op_nxt = la_ctrl_pkg::ALU_SUB;
      la_inst_pkg::ID_SLT, la_inst_pkg::ID_SLTI:      alu_op_nxt = la_ctrl_pkg::ALU_SLT;
      la_inst_pkg::ID_SLTU, la_inst_pkg::ID_SLTUI:    alu_op_nxt = la_ctrl_pkg::ALU_SLTU;
      la_inst_pkg::ID_XOR, la_inst_pkg::ID_XORI:      alu_op_nxt = la_ctrl_pkg::ALU_XOR;
      la_inst_pkg::ID_OR, la_inst_pkg::ID_ORI:        alu_op_nxt = la_ctrl_pkg::ALU_OR;
      la_inst_pkg::ID_AND, la_inst_pkg::ID_ANDI:      alu_op_nxt = la_ctrl_pkg::ALU_AND;
      la_inst_pkg::ID_SLL_W, la_inst_pkg::ID_SLLI_W:  alu_op_nxt = la_ctrl_pkg::ALU_SLL;
      la_inst_pkg::ID_SRL_W, la_inst_pkg::ID_SRLI_W:  alu_op_nxt = la_ctrl_pkg::ALU_SRL;
      la_inst_pkg::ID_SRA_W, la_inst_pkg::ID_SRAI_W:  alu_op_nxt = la_ctrl_pkg::ALU_SRA;
      la_inst_pkg::ID_NOR:                            alu_op_nxt = la_ctrl_pkg::ALU_NOR;
      la_inst_pkg::ID_LU12I_W:                        alu_op_nxt = la_ctrl_pkg::ALU_LUI;
      la_inst_pkg::ID_BEQ:                            alu_op_nxt = la_ctrl_pkg::ALU_BEQ;
      la_inst_pkg::ID_BNE:                            alu_op_nxt = la_ctrl_pkg::ALU_BNE;
      la_inst_pkg::ID_BLT:                            alu_op_nxt = la_ctrl_pkg::ALU_BLT;
      la_inst_pkg::ID_BGE:                            alu_op_nxt = la_ctrl_pkg::ALU_BGE;
      la_inst_pkg::ID_BLTU:                           alu_op_nxt = la_ctrl_pkg::ALU_BLTU;
      la_inst_pkg::ID_BGEU:                           alu_op_nxt = la_ctrl_pkg::ALU_BGEU;
      la_inst_pkg::ID_CSRRD, la_inst_pkg::ID_CSRWR,
      la_inst_pkg::ID_CSRXCHG:                        alu_op_nxt = la_ctrl_pkg::ALU_CSR;
      la_inst_pkg::ID_ERTN, la_inst_pkg::ID_SYSCALL,
      la_inst_pkg::ID_BREAK, la_inst_pkg::ID_INE:     alu_op_nxt = la_ctrl_pkg::ALU_NOP;
      default:                                        alu_op_nxt = la_ctrl_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    case (i_id)
      la_inst_pkg::ID_LD_H, la_inst_pkg::ID_ST_H: dm_type_nxt = la_ctrl_pkg::DM_H;
      la_inst_pkg::ID_LD_HU:                      dm_type_nxt = la_ctrl_pkg::DM_HU;
      la_inst_pkg::ID_LD_B, la_inst_pkg::ID_ST_B: dm_type_nxt = la_ctrl_pkg::DM_B;
      la_inst_pkg::ID_LD_BU:                      dm_type_nxt = la_ctrl_pkg::DM_BU;
      default:                                    dm_type_nxt = la_ctrl_pkg::DM_W;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // output slice

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_pc           <= i_pc;
      o_rd           <= rd_is_r1 ? 5'd1 : i_inst.r.rd;  // bl links into r1
      o_rs1          <= i_inst.r.rj;
      o_rs2          <= rs2_is_rd ? i_inst.r.rd : i_inst.r.rk;
      o_reg_write    <= reg_write_nxt;
      o_mem_write    <= mem_write_nxt;
      o_mem_read     <= mem_read_nxt;
      o_alu_op       <= alu_op_nxt;
      o_npc_op       <= npc_op_nxt;
      o_alu_src1_pc  <= src1_pc_nxt;
      o_alu_src2_imm <= src2_imm_nxt;
      o_wd_sel       <= wd_sel_nxt;
      o_dm_type      <= dm_type_nxt;
      o_imm_alu      <= imm_alu_nxt;
      o_imm_pc       <= imm_pc_nxt;
      o_csr_num      <= {i_inst.i.op_25_22[1:0], i_inst.i.imm_21_10};  // inst[23:10]
      o_csr_mask_en  <= csr_mask_nxt;
      o_csr_write    <= csr_write_nxt;
      o_ertn         <= (i_id == la_inst_pkg::ID_ERTN);
      o_sys          <= (i_id == la_inst_pkg::ID_SYSCALL);
      o_brk          <= (i_id == la_inst_pkg::ID_BREAK);
      o_ine          <= ine_nxt;
    end
  end

endmodule

// ==== hdl/la_decode_top.sv ====
`timescale 1ns/1ns
`include "la_decode_config.svh"

module la_decode_top (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_valid,
  input  la_inst_pkg::inst_word_u  i_inst,
  input  logic [`LA_XLEN-1:0]      i_pc,
  input  logic                     i_ready,
  output logic                     o_ready,
  output logic                     o_valid,
  output logic [`LA_XLEN-1:0]      o_pc,
  output logic [`LA_REG_AW-1:0]    o_rd,
  output logic [`LA_REG_AW-1:0]    o_rs1,
  output logic [`LA_REG_AW-1:0]    o_rs2,
  output logic                     o_reg_write,
  output logic                     o_mem_write,
  output logic                     o_mem_read,
  output la_ctrl_pkg::alu_op_e     o_alu_op,
  output la_ctrl_pkg::npc_op_e     o_npc_op,
  output logic                     o_alu_src1_pc,
  output logic                     o_alu_src2_imm,
  output la_ctrl_pkg::wd_sel_e     o_wd_sel,
  output la_ctrl_pkg::dm_type_e    o_dm_type,
  output logic [`LA_XLEN-1:0]      o_imm_alu,
  output logic [`LA_XLEN-1:0]      o_imm_pc,
  output logic [`LA_CSR_NUM_W-1:0] o_csr_num,
  output logic                     o_csr_mask_en,
  output logic                     o_csr_write,
  output logic                     o_ertn,
  output logic                     o_sys,
  output logic                     o_brk,
  output logic                     o_ine
);

  // stage 1 to stage 2
  logic                    s1_valid;
  logic                    s2_ready;
  la_inst_pkg::inst_id_e   s1_id;
  la_inst_pkg::inst_word_u s1_inst;
  logic [`LA_XLEN-1:0]     s1_pc;

  la_inst_match u_inst_match (
    .i_ready (s2_ready),
    .o_valid (s1_valid),
    .o_id    (s1_id),
    .o_inst  (s1_inst),
    .o_pc    (s1_pc),
    .*
  );

  // remaining ports share names with the top
  la_ctrl_gen u_ctrl_gen (
    .i_valid (s1_valid),
    .i_id    (s1_id),
    .i_inst  (s1_inst),
    .i_pc    (s1_pc),
    .o_ready (s2_ready),
    .*
  );

endmodule

// ==== verif/tb_la_decode_ref.svh ====
`ifndef TB_LA_DECODE_REF_SVH
`define TB_LA_DECODE_REF_SVH

// instruction kinds used by the stimulus
// 0-10 3R alu, 11-13 shift imm, 14-19 2RI12 alu, 20 lu12i, 21 pcaddu12i
// 22-26 loads, 27-29 stores, 30 jirl, 31 b, 32 bl, 33-38 cond branches
// 39 csrrd, 40 csrwr, 41 csrxchg, 42 ertn, 43 syscall, 44 break
// 45 zero word, 46 random unmatched word
localparam int NUM_KINDS = 47;

typedef struct packed {
  logic [31:0] pc;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic        reg_write;
  logic        mem_write;
  logic        mem_read;
  logic [4:0]  alu_op;
  logic [4:0]  npc_op;
  logic        src1_pc;
  logic        src2_imm;
  logic [1:0]  wd_sel;
  logic [2:0]  dm_type;
  logic [31:0] imm_alu;
  logic [31:0] imm_pc;
  logic [13:0] csr_num;
  logic        csr_mask_en;
  logic        csr_write;
  logic        ertn;
  logic        sys;
  logic        brk;
  logic        ine;
} ctrl_t;

function automatic logic [16:0] op17_of(input int k);
  case (k)
    0: return 17'h00020;
    1: return 17'h00022;
    2: return 17'h00024;
    3: return 17'h00025;
    4: return 17'h00028;
    5: return 17'h00029;
    6: return 17'h0002a;
    7: return 17'h0002b;
    8: return 17'h0002e;
    9: return 17'h0002f;
    10: return 17'h00030;
    11: return 17'h00081;
    12: return 17'h00089;
    13: return 17'h00091;
    43: return 17'h00056;
    default: return 17'h00054;  // break
  endcase
endfunction

// inst[31:22] of the 2RI12 alu and memory forms
function automatic logic [9:0] op10_of(input int k);
  case (k)
    14: return 10'h008;
    15: return 10'h009;
    16: return 10'h00a;
    17: return 10'h00d;
    18: return 10'h00e;
    19: return 10'h00f;
    22: return 10'h0a0;
    23: return 10'h0a1;
    24: return 10'h0a2;
    25: return 10'h0a8;
    26: return 10'h0a9;
    27: return 10'h0a4;
    28: return 10'h0a5;
    default: return 10'h0a6;
  endcase
endfunction

function automatic logic [4:0] alu_of(input int k);
  case (k)
    1: return la_ctrl_pkg::ALU_SUB;
    2, 14: return la_ctrl_pkg::ALU_SLT;
    3, 15: return la_ctrl_pkg::ALU_SLTU;
    4: return la_ctrl_pkg::ALU_NOR;
    5, 17: return la_ctrl_pkg::ALU_AND;
    6, 18: return la_ctrl_pkg::ALU_OR;
    7, 19: return la_ctrl_pkg::ALU_XOR;
    8, 11: return la_ctrl_pkg::ALU_SLL;
    9, 12: return la_ctrl_pkg::ALU_SRL;
    10, 13: return la_ctrl_pkg::ALU_SRA;
    20: return la_ctrl_pkg::ALU_LUI;
    33: return la_ctrl_pkg::ALU_BEQ;
    34: return la_ctrl_pkg::ALU_BNE;
    35: return la_ctrl_pkg::ALU_BLT;
    36: return la_ctrl_pkg::ALU_BGE;
    37: return la_ctrl_pkg::ALU_BLTU;
    38: return la_ctrl_pkg::ALU_BGEU;
    39, 40, 41: return la_ctrl_pkg::ALU_CSR;
    42, 43, 44, 45, 46: return la_ctrl_pkg::ALU_NOP;
    default: return la_ctrl_pkg::ALU_ADD;
  endcase
endfunction

function automatic logic [2:0] dm_of(input int k);
  case (k)
    22, 27: return la_ctrl_pkg::DM_B;
    23, 28: return la_ctrl_pkg::DM_H;
    25: return la_ctrl_pkg::DM_BU;
    26: return la_ctrl_pkg::DM_HU;
    default: return la_ctrl_pkg::DM_W;
  endcase
endfunction

// build a word of kind k, the random bits fill registers and immediates
function automatic logic [31:0] make_word(input int k, input logic [31:0] r);
  logic [4:0] rj_x;
  rj_x = (r[9:5] < 5'd2) ? 5'd2 : r[9:5];  // csrxchg needs rj above 1
  if (k <= 13 || k == 43 || k == 44) return {op17_of(k), r[14:0]};
  if ((k >= 14 && k <= 19) || (k >= 22 && k <= 29)) return {op10_of(k), r[21:0]};
  if (k == 20) return {7'b0001010, r[24:0]};
  if (k == 21) return {7'b0001110, r[24:0]};
  if (k >= 30 && k <= 38) return {6'h13 + 6'(k - 30), r[25:0]};
  if (k == 39) return {8'h04, r[23:10], 5'd0, r[4:0]};
  if (k == 40) return {8'h04, r[23:10], 5'd1, r[4:0]};
  if (k == 41) return {8'h04, r[23:10], rj_x, r[4:0]};
  if (k == 42) return 32'h06483800;
  if (k == 45) return 32'h0;
  return {1'b1, r[30:0]};  // top opcode bit set matches nothing
endfunction

function automatic ctrl_t expect_ctrl(input int k, input logic [31:0] w, input logic [31:0] pc);
  ctrl_t c;
  logic [31:0] off16;
  logic [31:0] off26;
  off16 = {{14{w[25]}}, w[25:10], 2'b00};
  off26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
  c = '0;
  c.pc      = pc;
  c.rd      = w[4:0];
  c.rs1     = w[9:5];
  c.rs2     = w[14:10];
  c.alu_op  = alu_of(k);
  c.npc_op  = la_ctrl_pkg::NPC_PLUS4;
  c.wd_sel  = la_ctrl_pkg::WD_ALU;
  c.dm_type = dm_of(k);
  c.imm_alu = {{20{w[21]}}, w[21:10]};
  c.csr_num = w[23:10];
  if (k <= 10) begin
    c.reg_write = 1'b1;
  end else if (k <= 13) begin
    c.reg_write = 1'b1;
    c.src2_imm  = 1'b1;
    c.imm_alu   = {27'd0, w[14:10]};
  end else if (k <= 19) begin
    c.reg_write = 1'b1;
    c.src2_imm  = 1'b1;
    if (k >= 17) c.imm_alu = {20'd0, w[21:10]};  // logic ops zero-extend
  end else if (k <= 21) begin
    c.reg_write = 1'b1;
    c.src2_imm  = 1'b1;
    c.src1_pc   = (k == 21);
    c.imm_alu   = {w[24:5], 12'd0};
  end else if (k <= 26) begin
    c.reg_write = 1'b1;
    c.src2_imm  = 1'b1;
    c.mem_read  = 1'b1;
    c.wd_sel    = la_ctrl_pkg::WD_MEM;
  end else if (k <= 29) begin
    c.mem_write = 1'b1;
    c.src2_imm  = 1'b1;
    c.rs2       = w[4:0];
  end else if (k == 30 || k == 32) begin
    c.reg_write = 1'b1;
    c.src1_pc   = 1'b1;
    c.src2_imm  = 1'b1;
    c.wd_sel    = la_ctrl_pkg::WD_PC;
    c.imm_alu   = 32'd4;
    c.imm_pc    = (k == 32) ? off26 : off16;
    c.npc_op    = (k == 32) ? la_ctrl_pkg::NPC_B : la_ctrl_pkg::NPC_JIRL;
    if (k == 32) c.rd = 5'd1;
  end else if (k == 31) begin
    c.npc_op  = la_ctrl_pkg::NPC_B;
    c.imm_alu = off26;
    c.imm_pc  = off26;
  end else if (k <= 38) begin
    c.npc_op  = la_ctrl_pkg::NPC_BRANCH;
    c.rs2     = w[4:0];
    c.imm_alu = off16;
    c.imm_pc  = off16;
  end else if (k <= 41) begin
    c.reg_write   = 1'b1;
    c.csr_write   = (k != 39);
    c.csr_mask_en = (k == 41);
    if (k != 39) c.rs2 = w[4:0];
  end else if (k == 42) begin
    c.ertn   = 1'b1;
    c.npc_op = la_ctrl_pkg::NPC_ERTN;
  end else if (k == 43) begin
    c.sys = 1'b1;
  end else if (k == 44) begin
    c.brk = 1'b1;
  end else begin
    c.ine = 1'b1;
  end
  return c;
endfunction

`endif

// ==== verif/tb_la_decode_top.sv ====
`timescale 1ns/1ns
`include "la_decode_config.svh"

module tb_la_decode_top;

  `include "tb_la_decode_ref.svh"

  localparam int N_INST  = 400;
  localparam int TIMEOUT = N_INST * 5;  // half throughput, double margin, plus reset

  logic                  i_clk;
  logic                  i_reset;
  logic                  i_valid;
  logic [31:0]           i_inst;
  logic [31:0]           i_pc;
  logic                  i_ready;
  logic                  o_ready;
  logic                  o_valid;
  logic [31:0]           o_pc;
  logic [4:0]            o_rd;
  logic [4:0]            o_rs1;
  logic [4:0]            o_rs2;
  logic                  o_reg_write;
  logic                  o_mem_write;
  logic                  o_mem_read;
  la_ctrl_pkg::alu_op_e  o_alu_op;
  la_ctrl_pkg::npc_op_e  o_npc_op;
  logic                  o_alu_src1_pc;
  logic                  o_alu_src2_imm;
  la_ctrl_pkg::wd_sel_e  o_wd_sel;
  la_ctrl_pkg::dm_type_e o_dm_type;
  logic [31:0]           o_imm_alu;
  logic [31:0]           o_imm_pc;
  logic [13:0]           o_csr_num;
  logic                  o_csr_mask_en;
  logic                  o_csr_write;
  logic                  o_ertn;
  logic                  o_sys;
  logic                  o_brk;
  logic                  o_ine;

  ctrl_t       act;
  ctrl_t       last_act;
  ctrl_t       exp_q[$];
  integer      seed;
  int          kind;
  int          n_sent;
  int          n_recv;
  int          cycles;
  logic        taken;
  logic        held;

  la_decode_top i_dut (.*);

  always #4 i_clk = ~i_clk;

  assign act = {o_pc, o_rd, o_rs1, o_rs2, o_reg_write, o_mem_write, o_mem_read,
                o_alu_op, o_npc_op, o_alu_src1_pc, o_alu_src2_imm, o_wd_sel, o_dm_type,
                o_imm_alu, o_imm_pc, o_csr_num, o_csr_mask_en, o_csr_write,
                o_ertn, o_sys, o_brk, o_ine};

  task automatic stop_failed();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] e, input logic [31:0] a);
    assert (e === a) else begin
      $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, e, a);
      stop_failed();
    end
  endtask

  task automatic compare_bundle(input ctrl_t e, input ctrl_t a);
    check_field("o_pc", e.pc, a.pc);
    check_field("o_rd", 32'(e.rd), 32'(a.rd));
    check_field("o_rs1", 32'(e.rs1), 32'(a.rs1));
    check_field("o_rs2", 32'(e.rs2), 32'(a.rs2));
    check_field("o_reg_write", 32'(e.reg_write), 32'(a.reg_write));
    check_field("o_mem_write", 32'(e.mem_write), 32'(a.mem_write));
    check_field("o_mem_read", 32'(e.mem_read), 32'(a.mem_read));
    check_field("o_alu_op", 32'(e.alu_op), 32'(a.alu_op));
    check_field("o_npc_op", 32'(e.npc_op), 32'(a.npc_op));
    check_field("o_alu_src1_pc", 32'(e.src1_pc), 32'(a.src1_pc));
    check_field("o_alu_src2_imm", 32'(e.src2_imm), 32'(a.src2_imm));
    check_field("o_wd_sel", 32'(e.wd_sel), 32'(a.wd_sel));
    check_field("o_dm_type", 32'(e.dm_type), 32'(a.dm_type));
    check_field("o_imm_alu", e.imm_alu, a.imm_alu);
    check_field("o_imm_pc", e.imm_pc, a.imm_pc);
    check_field("o_csr_num", 32'(e.csr_num), 32'(a.csr_num));
    check_field("o_csr_mask_en", 32'(e.csr_mask_en), 32'(a.csr_mask_en));
    check_field("o_csr_write", 32'(e.csr_write), 32'(a.csr_write));
    check_field("o_ertn", 32'(e.ertn), 32'(a.ertn));
    check_field("o_sys", 32'(e.sys), 32'(a.sys));
    check_field("o_brk", 32'(e.brk), 32'(a.brk));
    check_field("o_ine", 32'(e.ine), 32'(a.ine));
  endtask

  ////////////////////////////////////////////////////////////
  // scoreboard, hold check and timeout

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: decode outputs did not all arrive in time");
      stop_failed();
    end
    taken = !i_reset && i_valid && o_ready;
    if (!i_reset) begin
      // only a full pipe with a stalled output may refuse input
      check_field("o_ready", 32'(!(exp_q.size() >= 2 && !i_ready)), 32'(o_ready));
      if (held) begin
        check_field("o_valid", 32'd1, 32'(o_valid));  // held item may not vanish
        compare_bundle(last_act, act);
      end
      if (taken) begin
        exp_q.push_back(expect_ctrl(kind, i_inst, i_pc));
        n_sent = n_sent + 1;
      end
      if (o_valid && i_ready) begin
        if (exp_q.size() == 0) begin
          $display("an output was produced with no matching input");
          stop_failed();
        end
        compare_bundle(exp_q.pop_front(), act);
        n_recv = n_recv + 1;
      end
    end
    held     = !i_reset && o_valid && !i_ready;
    last_act = act;
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    i_clk   = 1'b0;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_inst  = '0;
    i_pc    = '0;
    i_ready = 1'b0;
    seed    = 32'hac9a_de8d;
    kind    = 45;
    n_sent  = 0;
    n_recv  = 0;
    cycles  = 0;
    taken   = 1'b0;
    held    = 1'b0;
    repeat (8) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    check_field("o_valid", 32'd0, 32'(o_valid));
    check_field("o_ready", 32'd1, 32'(o_ready));
    while (n_sent < N_INST) begin
      if (taken || !i_valid) begin
        i_valid = (($random(seed) % 4) != 0);
        kind    = $unsigned($random(seed)) % NUM_KINDS;
        i_inst  = make_word(kind, $random(seed));
        i_pc    = $random(seed);
        i_pc[1:0] = 2'b00;
      end
      i_ready = $random(seed) & 1;  // back-pressure about half the time
      @(posedge i_clk);
      #1;
    end
    i_valid = 1'b0;
    while (n_recv < N_INST) begin
      i_ready = $random(seed) & 1;
      @(posedge i_clk);
      #1;
    end
    // idle with the output stalled, a stray item would show up here
    i_ready = 1'b0;
    repeat (4) @(posedge i_clk);
    #1;
    if (!o_valid) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("an extra output appeared after the last instruction");
      stop_failed();
    end
  end

endmodule

// ==== la_decode_top.f ====
+incdir+hdl
+incdir+verif
hdl/la_inst_pkg.sv
hdl/la_ctrl_pkg.sv
hdl/la_inst_match.sv
hdl/la_imm_gen.sv
hdl/la_ctrl_gen.sv
hdl/la_decode_top.sv
verif/tb_la_decode_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode testbench, exit status follows the simulation
rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f la_decode_top.f \
  --top-module tb_la_decode_top -o Vtb_la_decode_top \
  && ./obj_dir/Vtb_la_decode_top \
  || { echo "simulation failed"; exit 1; }
